// ==== rtl/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Instruction and address width.
`define WORD_SIZE 32

// Cache line geometry.
`define LINE_WORDS 4
`define LINE_SIZE 128
`define CACHE_LINES 16
`define INDEX_SIZE 4
`define TAG_SIZE 24
`define LINE_ADDR_SIZE 28

// Reset vector and bubble encoding (addi x0,x0,0).
`define PC_INITIAL 32'h0000_0000
`define NOP 32'h0000_0013

// Backing store.
`define MEM_LATENCY 4
`define MEM_WORDS 256
`define WORD_ADDR_SIZE 8

`endif

// ==== rtl/fetchPkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetchPkg;

   // Bundle handed from fetch to decode.
   typedef struct packed {
      logic                  valid;
      logic [`WORD_SIZE-1:0] instr;
      logic [`WORD_SIZE-1:0] pc;
      logic [`WORD_SIZE-1:0] pcPlus4;
   } decodeBundleT;

   // Branch or jump redirect from execute.
   typedef struct packed {
      logic                  valid;
      logic [`WORD_SIZE-1:0] target;
   } redirectT;

   // Cache refill request for one line address.
   typedef struct packed {
      logic                       read;
      logic [`LINE_ADDR_SIZE-1:0] lineAddr;
   } lineReqT;

   typedef struct packed {
      logic                  ready;
      logic [`LINE_SIZE-1:0] line;
   } lineRespT;

   // Boot loader preload write.
   typedef struct packed {
      logic                       write;
      logic [`WORD_ADDR_SIZE-1:0] wordAddr;
      logic [`WORD_SIZE-1:0]      data;
   } memLoadT;

endpackage

`default_nettype wire

// ==== rtl/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module programCounter (
   input  wire                         clk,
   input  wire                         rst,
   input  fetchPkg::redirectT          redirect,
   input  wire                         stallF,
   input  wire                         cacheStall,
   output logic [`WORD_SIZE-1:0]       pc
);

   logic [`WORD_SIZE-1:0] pcNext;

   // Redirect wins over any hold.
   always_comb begin
      if (redirect.valid) begin
         pcNext = redirect.target;
      end else if (stallF || cacheStall) begin
         pcNext = pc;
      end else begin
         pcNext = pc + `WORD_SIZE'd4;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pc <= `PC_INITIAL;
      end else begin
         pc <= pcNext;
      end
   end

   // Targets from execute must keep fetch word-aligned.
   pcAligned: assert property (@(posedge clk) disable iff (rst)
      pc[1:0] == 2'b00)
      else $error("fetch PC is not word-aligned: %h", pc);

endmodule

`default_nettype wire

// ==== rtl/iCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module iCache (
   input  wire                         clk,
   input  wire                         rst,
   input  wire  [`WORD_SIZE-1:0]       pc,
   input  fetchPkg::lineRespT          lineResp,
   output logic [`WORD_SIZE-1:0]       instr,
   output logic                        cacheStall,
   output fetchPkg::lineReqT           lineReq
);

   typedef enum logic {
      LOOKUP,
      REFILL
   } cacheStateT;

   cacheStateT state;

   // Per-line storage.
   logic [`CACHE_LINES-1:0] validBits;
   logic [`TAG_SIZE-1:0]    tagArray  [`CACHE_LINES];
   logic [`LINE_SIZE-1:0]   dataArray [`CACHE_LINES];

   // Address split of the current PC.
   logic [`TAG_SIZE-1:0]       pcTag;
   logic [`INDEX_SIZE-1:0]     pcIndex;
   logic [1:0]                 pcWord;
   logic [`LINE_ADDR_SIZE-1:0] pcLine;

   // Line being refilled is kept so a redirect cannot disturb it.
   logic [`LINE_ADDR_SIZE-1:0] refillLine;
   logic [`INDEX_SIZE-1:0]     refillIndex;

   logic hit;

   assign pcLine  = pc[`WORD_SIZE-1:4];
   assign pcTag   = pc[`WORD_SIZE-1:8];
   assign pcIndex = pc[7:4];
   assign pcWord  = pc[3:2];

   assign refillIndex = refillLine[`INDEX_SIZE-1:0];

   assign hit = validBits[pcIndex] && (tagArray[pcIndex] == pcTag);

   // Word select within the indexed line.
   assign instr = dataArray[pcIndex][pcWord*`WORD_SIZE +: `WORD_SIZE];

   // Stall for the whole refill, even if a redirect lands on a hit.
   assign cacheStall = (state == REFILL) || !hit;

   always_comb begin
      lineReq.read = cacheStall;
      if (state == REFILL) begin
         lineReq.lineAddr = refillLine;
      end else begin
         lineReq.lineAddr = pcLine;
      end
   end

   // Miss controller.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= LOOKUP;
         validBits <= '0;
      end else begin
         case (state)
            LOOKUP: begin
               if (!hit) begin
                  state <= REFILL;
               end
            end
            REFILL: begin
               if (lineResp.ready) begin
                  validBits[refillIndex] <= 1'b1;
                  state                  <= LOOKUP;
               end
            end
            default: state <= LOOKUP;
         endcase
      end
   end

   // Missed line address is captured on entry to refill.
   always_ff @(posedge clk) begin
      if (state == LOOKUP && !hit) begin
         refillLine <= pcLine;
      end
   end

   always_ff @(posedge clk) begin
      if (state == REFILL && lineResp.ready) begin
         tagArray[refillIndex]  <= refillLine[`LINE_ADDR_SIZE-1:`INDEX_SIZE];
         dataArray[refillIndex] <= lineResp.line;
      end
   end

   // Request is a level held until the line comes back.
   readHeld: assert property (@(posedge clk) disable iff (rst)
      lineReq.read && !lineResp.ready |=> lineReq.read)
      else $error("refill read dropped before ready");

   // The memory only answers an outstanding refill.
   readyInRefill: assert property (@(posedge clk) disable iff (rst)
      lineResp.ready |-> state == REFILL)
      else $error("line ready while cache is in lookup");

   // A freshly filled line hits while the PC still points into it.
   fillHits: assert property (@(posedge clk) disable iff (rst)
      (state == REFILL && lineResp.ready) |=> (pcLine != refillLine || !cacheStall))
      else $error("cache stalled on a freshly filled line");

endmodule

`default_nettype wire

// ==== rtl/lineMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module lineMemory (
   input  wire                         clk,
   input  wire                         rst,
   input  fetchPkg::lineReqT           lineReq,
   input  fetchPkg::memLoadT           memLoad,
   output fetchPkg::lineRespT          lineResp
);

   localparam int CntBits  = $clog2(`MEM_LATENCY + 1);
   localparam int LineBits = `WORD_ADDR_SIZE - 2;

   logic [`WORD_SIZE-1:0] mem [`MEM_WORDS];

   logic                busy;
   logic [CntBits-1:0]  cnt;
   logic [LineBits-1:0] reqLine;

   // Boot preload writes one word per cycle.
   always_ff @(posedge clk) begin
      if (memLoad.write) begin
         mem[memLoad.wordAddr] <= memLoad.data;
      end
   end

   // Latency counter starts at the first sample of read.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (busy) begin
         if (cnt == CntBits'(`MEM_LATENCY)) begin
            busy <= 1'b0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end else if (lineReq.read) begin
         busy <= 1'b1;
         cnt  <= CntBits'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (!busy && lineReq.read) begin
         reqLine <= lineReq.lineAddr[LineBits-1:0];
      end
   end

   // Lowest word address lands in the low bits of the line.
   always_comb begin
      lineResp.ready = busy && (cnt == CntBits'(`MEM_LATENCY));
      for (int i = 0; i < `LINE_WORDS; i++) begin
         lineResp.line[i*`WORD_SIZE +: `WORD_SIZE] = mem[{reqLine, 2'(i)}];
      end
   end

   // Preload must finish before fetch starts missing.
   noLoadDuringRead: assert property (@(posedge clk) disable iff (rst)
      memLoad.write |-> !busy)
      else $error("preload write while a line read is pending");

endmodule

`default_nettype wire

// ==== rtl/decodeLatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module decodeLatch (
   input  wire                         clk,
   input  wire                         rst,
   input  wire  [`WORD_SIZE-1:0]       pc,
   input  wire  [`WORD_SIZE-1:0]       instr,
   input  wire                         stallD,
   input  wire                         flushD,
   input  wire                         cacheStall,
   output fetchPkg::decodeBundleT      decode
);

   fetchPkg::decodeBundleT bubble;
   fetchPkg::decodeBundleT fetched;

   assign bubble.valid   = 1'b0;
   assign bubble.instr   = `NOP;
   assign bubble.pc      = pc;
   assign bubble.pcPlus4 = pc + `WORD_SIZE'd4;

   assign fetched.valid   = 1'b1;
   assign fetched.instr   = instr;
   assign fetched.pc      = pc;
   assign fetched.pcPlus4 = pc + `WORD_SIZE'd4;

   // Flush beats stall, stall beats a miss bubble.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         decode <= '{valid: 1'b0, instr: `NOP, pc: `PC_INITIAL,
                     pcPlus4: `PC_INITIAL + `WORD_SIZE'd4};
      end else if (flushD) begin
         decode <= bubble;
      end else if (stallD) begin
         decode <= decode;
      end else if (cacheStall) begin
         decode <= bubble;
      end else begin
         decode <= fetched;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetchStage (
   input  wire                         clk,
   input  wire                         rst,
   input  fetchPkg::redirectT          redirect,
   input  wire                         stallF,
   input  wire                         stallD,
   input  wire                         flushD,
   input  fetchPkg::memLoadT           memLoad,
   output fetchPkg::decodeBundleT      decode,
   output logic                        cacheStall
);

   logic [`WORD_SIZE-1:0] pcF;
   logic [`WORD_SIZE-1:0] instrF;
   fetchPkg::lineReqT     lineReq;
   fetchPkg::lineRespT    lineResp;

   programCounter pc0 (
      .clk        (clk),
      .rst        (rst),
      .redirect   (redirect),
      .stallF     (stallF),
      .cacheStall (cacheStall),
      .pc         (pcF)
   );

   iCache cache0 (
      .clk        (clk),
      .rst        (rst),
      .pc         (pcF),
      .lineResp   (lineResp),
      .instr      (instrF),
      .cacheStall (cacheStall),
      .lineReq    (lineReq)
   );

   // Line-wide backing store behind the cache.
   lineMemory mem0 (
      .clk      (clk),
      .rst      (rst),
      .lineReq  (lineReq),
      .memLoad  (memLoad),
      .lineResp (lineResp)
   );

   decodeLatch latch0 (
      .clk        (clk),
      .rst        (rst),
      .pc         (pcF),
      .instr      (instrF),
      .stallD     (stallD),
      .flushD     (flushD),
      .cacheStall (cacheStall),
      .decode     (decode)
   );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic clk,
   output logic rst
);

   // 40 ns period.
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Reset is held for five cycles and released on a falling edge.
   initial begin
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== verification/fetchStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetchStageTb;

   localparam int BundleTimeout = 60;
   localparam int ResetTimeout  = 100;
   localparam int MissCycles    = `MEM_LATENCY + 1;

   logic                   clk;
   logic                   rstGen;
   logic                   loading;
   logic                   rst;
   fetchPkg::redirectT     redirect;
   logic                   stallF;
   logic                   stallD;
   logic                   flushD;
   fetchPkg::memLoadT      memLoad;
   fetchPkg::decodeBundleT decode;
   logic                   cacheStall;

   // Preload runs with the DUT still in reset.
   assign rst = rstGen || loading;

   clockGen clk0 (
      .clk (clk),
      .rst (rstGen)
   );

   fetchStage dut0 (
      .clk        (clk),
      .rst        (rst),
      .redirect   (redirect),
      .stallF     (stallF),
      .stallD     (stallD),
      .flushD     (flushD),
      .memLoad    (memLoad),
      .decode     (decode),
      .cacheStall (cacheStall)
   );

   // Golden file contents.
   logic [31:0] loadAddr[$];
   logic [31:0] loadData[$];
   int          redirAfter[$];
   logic [31:0] redirTarget[$];
   logic [31:0] expPc[$];
   logic [31:0] expInstr[$];
   bit          expMiss[$];
   logic [31:0] image [`MEM_WORDS];

   int                     seed;
   int                     bundleCount;
   int                     redirIdx;
   int                     runLen;
   bit                     runRedirect;
   bit                     stallSeen;
   bit                     prevStall;
   bit                     lastStallD;
   bit                     lastFlush;
   bit                     targetPending;
   logic [31:0]            targetPc;
   fetchPkg::decodeBundleT prevDecode;

   task automatic failValue(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "wrong value from the DUT");
   endtask

   task automatic failPlain(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic checkBundle(input fetchPkg::decodeBundleT expected,
                              input fetchPkg::decodeBundleT actual, input string what);
      if (actual !== expected) begin
         failValue($sformatf("%s: expected v=%0b i=%h pc=%h p4=%h, got v=%0b i=%h pc=%h p4=%h",
            what, expected.valid, expected.instr, expected.pc, expected.pcPlus4,
            actual.valid, actual.instr, actual.pc, actual.pcPlus4));
      end
   endtask

   task automatic checkStall(input logic expected, input logic actual, input string what);
      if (actual !== expected) begin
         failValue($sformatf("%s: expected cacheStall=%0b, got %0b", what, expected, actual));
      end
   endtask

   task automatic readGolden();
      int                fd;
      int                n;
      int                cnt;
      logic [7:0]        kind;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [8*256-1:0]  rest;
      fd = $fopen("verification/fetch_golden.txt", "r");
      if (fd == 0) begin
         failPlain("Could not open the golden file.");
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, " %c", kind);
         if (n != 1) begin
            break;
         end
         case (kind)
            "#": n = $fgets(rest, fd);
            "P": begin
               n = $fscanf(fd, "%h %h", a, b);
               loadAddr.push_back(a);
               loadData.push_back(b);
            end
            "R": begin
               n = $fscanf(fd, "%d %h", cnt, a);
               redirAfter.push_back(cnt);
               redirTarget.push_back(a);
            end
            "E": begin
               n = $fscanf(fd, "%h %h %d", a, b, cnt);
               expPc.push_back(a);
               expInstr.push_back(b);
               expMiss.push_back(cnt != 0);
            end
            default: failPlain("The golden file holds an unknown record type.");
         endcase
      end
      $fclose(fd);
   endtask

   // Checks what the last edge produced, then drives the next inputs.
   task automatic stepCycle(output bit gotNew);
      fetchPkg::decodeBundleT expected;
      logic [31:0]            r;
      bit                     s;
      gotNew = 1'b0;
      @(negedge clk);
      s = cacheStall;
      if (lastFlush) begin
         if (decode.valid) begin
            failValue("flushed bundle appeared as valid");
         end
      end else if (lastStallD) begin
         checkBundle(prevDecode, decode, "decode held under stallD");
      end else if (decode.valid) begin
         if (bundleCount >= expPc.size()) begin
            failValue("more valid bundles than expected");
         end
         expected = '{valid: 1'b1, instr: expInstr[bundleCount], pc: expPc[bundleCount],
                      pcPlus4: expPc[bundleCount] + 32'd4};
         checkBundle(expected, decode, $sformatf("bundle %0d", bundleCount + 1));
         if (decode.instr !== image[decode.pc[9:2]]) begin
            failValue($sformatf("instr at pc %h differs from the preloaded word", decode.pc));
         end
         if (targetPending && decode.pc !== targetPc) begin
            failValue($sformatf("first bundle after redirect is not at target %h", targetPc));
         end
         if (stallSeen != expMiss[bundleCount]) begin
            failValue($sformatf("bundle %0d: miss seen=%0b, expected %0b",
               bundleCount + 1, stallSeen, expMiss[bundleCount]));
         end
         targetPending = 1'b0;
         stallSeen     = 1'b0;
         bundleCount++;
         gotNew = 1'b1;
      end else begin
         checkStall(1'b1, prevStall, "bubble in decode without a cache stall");
      end

      // A refill stalls MEM_LATENCY+1 cycles unless a redirect chained a second miss.
      if (runLen > 0 && !runRedirect) begin
         if (runLen < MissCycles) begin
            checkStall(1'b1, s, "refill ended early");
         end else begin
            checkStall(1'b0, s, "refill lasted too long");
         end
      end
      if (s) begin
         runLen++;
         stallSeen = 1'b1;
      end else begin
         if (runRedirect && (runLen % MissCycles) != 0) begin
            failValue($sformatf("stall run of %0d cycles around a redirect", runLen));
         end
         runLen      = 0;
         runRedirect = 1'b0;
      end
      prevStall  = s;
      prevDecode = decode;

      redirect = '0;
      flushD   = 1'b0;
      if (redirIdx < redirAfter.size() && bundleCount == redirAfter[redirIdx]) begin
         redirect.valid  = 1'b1;
         redirect.target = redirTarget[redirIdx];
         flushD          = 1'b1;
         stallF          = 1'b0;
         stallD          = 1'b0;
         targetPending   = 1'b1;
         targetPc        = redirTarget[redirIdx];
         if (s) begin
            runRedirect = 1'b1;
         end
         redirIdx++;
      end else begin
         // Hazard unit stalls fetch and decode together.
         r      = $random(seed);
         stallD = (r[1:0] == 2'b00);
         stallF = stallD;
      end
      lastStallD = stallD;
      lastFlush  = flushD;
   endtask

   task automatic waitBundle();
      bit got;
      int c;
      got = 1'b0;
      for (c = 0; c < BundleTimeout && !got; c++) begin
         stepCycle(got);
      end
      if (!got) begin
         failPlain($sformatf("Timed out waiting for valid bundle %0d.", bundleCount + 1));
      end
   endtask

   initial begin
      int c;
      seed          = 32'h9977189a;
      loading       = 1'b1;
      redirect      = '0;
      stallF        = 1'b0;
      stallD        = 1'b0;
      flushD        = 1'b0;
      memLoad       = '0;
      bundleCount   = 0;
      redirIdx      = 0;
      runRedirect   = 1'b0;
      lastStallD    = 1'b0;
      lastFlush     = 1'b0;
      targetPending = 1'b0;
      targetPc      = '0;
      readGolden();

      // Boot preload writes one word per cycle.
      for (c = 0; c < loadAddr.size(); c++) begin
         @(negedge clk);
         memLoad = '{write: 1'b1, wordAddr: loadAddr[c][9:2], data: loadData[c]};
         image[loadAddr[c][9:2]] = loadData[c];
      end
      @(negedge clk);
      memLoad = '0;
      for (c = 0; c < ResetTimeout && rstGen; c++) begin
         @(negedge clk);
      end
      if (rstGen) begin
         failPlain("Reset from the clock generator never released.");
      end
      loading = 1'b0;

      checkBundle('{valid: 1'b0, instr: `NOP, pc: `PC_INITIAL, pcPlus4: `PC_INITIAL + 32'd4},
                  decode, "decode after reset");
      prevStall  = cacheStall;
      stallSeen  = cacheStall;
      runLen     = cacheStall ? 1 : 0;
      prevDecode = decode;

      for (c = 0; c < expPc.size(); c++) begin
         waitBundle();
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/fetch_golden.txt ====
# P byteAddr data = preload; R count target = redirect after count bundles; E pc instr miss
P 000 00500093
P 004 00a00113
P 008 002081b3
P 00c 40110233
P 010 0041a2b3
P 014 00229313
P 018 0062d393
P 01c 00000463
P 0f0 0ff00513
P 0f4 00a50593
P 0f8 00b50633
P 0fc 00c586b3
P 100 10000713
P 104 00170793
P 108 00278813
P 10c 00380893
R 7 000
R 14 100
R 18 000
R 24 100
R 27 0f0
E 000 00500093 1
E 004 00a00113 0
E 008 002081b3 0
E 00c 40110233 0
E 010 0041a2b3 1
E 014 00229313 0
E 018 0062d393 0
E 000 00500093 0
E 004 00a00113 0
E 008 002081b3 0
E 00c 40110233 0
E 010 0041a2b3 0
E 014 00229313 0
E 018 0062d393 0
E 100 10000713 1
E 104 00170793 0
E 108 00278813 0
E 10c 00380893 0
E 000 00500093 1
E 004 00a00113 0
E 008 002081b3 0
E 00c 40110233 0
E 010 0041a2b3 1
E 014 00229313 0
E 100 10000713 1
E 104 00170793 0
E 108 00278813 0
E 0f0 0ff00513 1
E 0f4 00a50593 0
E 0f8 00b50633 0
E 0fc 00c586b3 0
E 100 10000713 0
E 104 00170793 0

// ==== verilog.f ====
+incdir+rtl
rtl/fetchPkg.sv
rtl/programCounter.sv
rtl/iCache.sv
rtl/lineMemory.sv
rtl/decodeLatch.sv
rtl/fetchStage.sv
verification/clockGen.sv
verification/fetchStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module fetchStageTb -o fetchStageTb
./obj_dir/fetchStageTb
